// ==== verilog/adc_pkg.sv ====
package adc_pkg;

	// ----------------------------------------------------------------------
	// lvds output format.
	// ----------------------------------------------------------------------
	localparam int lane_cnt       = 8;
	localparam int ser_ratio      = 8;
	localparam int chan_cnt       = 4;
	localparam int sample_width   = 16;
	localparam int lane_word_bits = lane_cnt * ser_ratio;
	localparam int bit_cnt_width  = $clog2(ser_ratio);

	// frame lane is high for the first half of each word.
	localparam logic [ser_ratio-1:0] frame_pattern = 8'hf0;
	// board polarity swaps, one bit per data lane.
	localparam logic [lane_cnt-1:0]  lane_invert   = 8'h00;

	// word alignment.
	localparam int lock_count   = 4;
	localparam int settle_words = 2;
	localparam int match_width  = $clog2(lock_count);
	localparam int settle_width = $clog2(settle_words + 1);

	// ----------------------------------------------------------------------
	// spi configuration port.
	// ----------------------------------------------------------------------
	localparam int spi_addr_width = 13;
	localparam int spi_data_width = 8;
	localparam int spi_frame_bits = 24;
	localparam int spi_instr_bits = spi_frame_bits - spi_data_width;
	localparam int spi_div        = 4;
	localparam int spi_div_width  = $clog2(spi_div);
	localparam int spi_cnt_width  = $clog2(spi_frame_bits);

	// spi master states.
	localparam logic [1:0] st_idle  = 2'd0;
	localparam logic [1:0] st_shift = 2'd1;
	localparam logic [1:0] st_done  = 2'd2;

endpackage

// ==== verilog/lane_bank.sv ====
`timescale 1ns/100ps

module lane_bank (
	input  logic                               dco_clk,
	input  logic                               reset,
	input  logic [adc_pkg::lane_cnt-1:0]       lane_in,
	input  logic                               frame_in,
	input  logic                               slip,
	output logic [adc_pkg::lane_word_bits-1:0] lane_words,
	output logic [adc_pkg::ser_ratio-1:0]      frame_word,
	output logic                               word_valid
);

	import adc_pkg::*;

	// index lane_cnt is the frame lane.
	logic [lane_cnt:0]        bits_in;
	logic [ser_ratio-1:0]     shift_q [lane_cnt+1];
	logic [ser_ratio-1:0]     next_word [lane_cnt+1];
	logic [bit_cnt_width-1:0] bit_cnt;
	logic                     boundary;

	assign bits_in  = {frame_in, lane_in ^ lane_invert};
	assign boundary = (bit_cnt == bit_cnt_width'(ser_ratio - 1)) && !slip;

	// first bit on the wire ends up in the msb.
	always_comb begin
		for (int i = 0; i <= lane_cnt; i++) begin
			next_word[i] = {shift_q[i][ser_ratio-2:0], bits_in[i]};
		end
	end

	always_ff @(posedge dco_clk) begin
		for (int i = 0; i <= lane_cnt; i++) begin
			shift_q[i] <= next_word[i];
		end
	end

	// a slip stalls the counter, moving the boundary one bit later.
	always_ff @(posedge dco_clk) begin
		if (reset) begin
			bit_cnt    <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= boundary;
			if (!slip)
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

	always_ff @(posedge dco_clk) begin
		if (boundary) begin
			for (int i = 0; i < lane_cnt; i++) begin
				lane_words[i*ser_ratio +: ser_ratio] <= next_word[i];
			end
			frame_word <= next_word[lane_cnt];
		end
	end

endmodule

// ==== verilog/frame_align.sv ====
`timescale 1ns/100ps

module frame_align (
	input  logic                          dco_clk,
	input  logic                          reset,
	input  logic [adc_pkg::ser_ratio-1:0] frame_word,
	input  logic                          word_valid,
	output logic                          slip,
	output logic                          frame_locked
);

	import adc_pkg::*;

	logic [match_width-1:0]  match_cnt;
	logic [settle_width-1:0] settle_cnt;
	logic                    compare;
	logic                    match;

	// words arriving right after a slip are still shifting into place.
	assign compare = word_valid && (settle_cnt == '0);
	assign match   = (frame_word == frame_pattern);

	// only slip while hunting. a lost lock waits for the next mismatch.
	assign slip = compare && !match && !frame_locked;

	// ----------------------------------------------------------------------
	// lock tracking.
	// ----------------------------------------------------------------------
	always_ff @(posedge dco_clk) begin
		if (reset) begin
			match_cnt    <= '0;
			settle_cnt   <= '0;
			frame_locked <= 1'b0;
		end else if (word_valid) begin
			if (settle_cnt != '0) begin
				settle_cnt <= settle_cnt - 1'b1;
			end else if (match) begin
				if (!frame_locked) begin
					if (match_cnt == match_width'(lock_count - 1)) begin
						frame_locked <= 1'b1;
						match_cnt    <= '0;
					end else begin
						match_cnt <= match_cnt + 1'b1;
					end
				end
			end else begin
				match_cnt <= '0;
				if (frame_locked)
					frame_locked <= 1'b0;
				else
					settle_cnt <= settle_width'(settle_words);
			end
		end
	end

endmodule

// ==== verilog/sample_assembler.sv ====
`timescale 1ns/100ps

module sample_assembler (
	input  logic                               dco_clk,
	input  logic                               reset,
	input  logic [adc_pkg::lane_word_bits-1:0] lane_words,
	input  logic                               word_valid,
	input  logic                               frame_locked,
	output logic [adc_pkg::sample_width-1:0]   sample_a,
	output logic [adc_pkg::sample_width-1:0]   sample_b,
	output logic [adc_pkg::sample_width-1:0]   sample_c,
	output logic [adc_pkg::sample_width-1:0]   sample_d,
	output logic                               sample_valid
);

	import adc_pkg::*;

	logic [sample_width-1:0] sample_next [chan_cnt];
	logic                    valid_q;

	// odd lane of each pair is d1, its bits land on the odd sample bits.
	always_comb begin
		for (int ch = 0; ch < chan_cnt; ch++) begin
			for (int b = 0; b < ser_ratio; b++) begin
				sample_next[ch][2*b+1] = lane_words[(2*ch+1)*ser_ratio + b];
				sample_next[ch][2*b]   = lane_words[2*ch*ser_ratio + b];
			end
		end
	end

	// channel a sits on the top lane pair.
	always_ff @(posedge dco_clk) begin
		if (word_valid) begin
			sample_a <= sample_next[3];
			sample_b <= sample_next[2];
			sample_c <= sample_next[1];
			sample_d <= sample_next[0];
		end
	end

	always_ff @(posedge dco_clk) begin
		if (reset)
			valid_q <= 1'b0;
		else
			valid_q <= word_valid;
	end

	// word that breaks lock is dropped here.
	assign sample_valid = valid_q && frame_locked;

endmodule

// ==== verilog/spi_master.sv ====
`timescale 1ns/100ps

module spi_master (
	input  logic                               dco_clk,
	input  logic                               reset,
	input  logic                               cfg_req,
	input  logic                               cfg_rw,
	input  logic [adc_pkg::spi_addr_width-1:0] cfg_addr,
	input  logic [adc_pkg::spi_data_width-1:0] cfg_wdata,
	input  logic                               sdio_in,
	output logic                               cfg_ack,
	output logic [adc_pkg::spi_data_width-1:0] cfg_rdata,
	output logic                               csb,
	output logic                               sclk,
	output logic                               sdio_out,
	output logic                               sdio_oe
);

	import adc_pkg::*;

	logic [1:0]                state;
	logic [spi_div_width-1:0]  div_cnt;
	logic [spi_cnt_width-1:0]  bit_cnt;
	logic [spi_frame_bits-1:0] tx_q;
	logic [spi_data_width-1:0] rx_q;
	logic                      is_read;
	logic                      div_tick;

	assign div_tick = (div_cnt == spi_div_width'(spi_div - 1));
	assign sdio_out = tx_q[spi_frame_bits-1];

	// ----------------------------------------------------------------------
	// control fsm.
	// ----------------------------------------------------------------------
	always_ff @(posedge dco_clk) begin
		if (reset) begin
			state   <= st_idle;
			div_cnt <= '0;
			bit_cnt <= '0;
			is_read <= 1'b0;
			csb     <= 1'b1;
			sclk    <= 1'b0;
			sdio_oe <= 1'b1;
			cfg_ack <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (cfg_req) begin
						state   <= st_shift;
						csb     <= 1'b0;
						div_cnt <= '0;
						bit_cnt <= '0;
						is_read <= cfg_rw;
					end
				end
				st_shift: begin
					div_cnt <= div_tick ? '0 : div_cnt + 1'b1;
					if (div_tick) begin
						sclk <= !sclk;
						// falling edge closes one bit.
						if (sclk) begin
							bit_cnt <= bit_cnt + 1'b1;
							if (is_read && bit_cnt == spi_cnt_width'(spi_instr_bits - 1))
								sdio_oe <= 1'b0;
							if (bit_cnt == spi_cnt_width'(spi_frame_bits - 1))
								state <= st_done;
						end
					end
				end
				st_done: begin
					// csb rises one cycle after the last sclk fall.
					if (!csb) begin
						csb     <= 1'b1;
						sdio_oe <= 1'b1;
						cfg_ack <= 1'b1;
					end else if (!cfg_req) begin
						cfg_ack <= 1'b0;
						state   <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// shift path.
	// ----------------------------------------------------------------------
	always_ff @(posedge dco_clk) begin
		if (state == st_idle && cfg_req) begin
			// rw, two zero width bits, address, then data.
			tx_q <= {cfg_rw, 2'b00, cfg_addr, cfg_wdata};
		end else if (state == st_shift && div_tick) begin
			if (sclk)
				tx_q <= {tx_q[spi_frame_bits-2:0], 1'b0};
			else if (is_read && bit_cnt >= spi_cnt_width'(spi_instr_bits))
				rx_q <= {rx_q[spi_data_width-2:0], sdio_in};
		end
	end

	always_ff @(posedge dco_clk) begin
		if (state == st_done && !csb && is_read)
			cfg_rdata <= rx_q;
	end

endmodule

// ==== verilog/adc_rx_top.sv ====
`timescale 1ns/100ps

module adc_rx_top (
	input  logic                               dco_clk,
	input  logic                               reset,
	input  logic                               d0a,
	input  logic                               d1a,
	input  logic                               d0b,
	input  logic                               d1b,
	input  logic                               d0c,
	input  logic                               d1c,
	input  logic                               d0d,
	input  logic                               d1d,
	input  logic                               fco,
	input  logic                               cfg_req,
	input  logic                               cfg_rw,
	input  logic [adc_pkg::spi_addr_width-1:0] cfg_addr,
	input  logic [adc_pkg::spi_data_width-1:0] cfg_wdata,
	input  logic                               sdio_in,
	output logic [adc_pkg::sample_width-1:0]   sample_a,
	output logic [adc_pkg::sample_width-1:0]   sample_b,
	output logic [adc_pkg::sample_width-1:0]   sample_c,
	output logic [adc_pkg::sample_width-1:0]   sample_d,
	output logic                               sample_valid,
	output logic                               frame_locked,
	output logic                               cfg_ack,
	output logic [adc_pkg::spi_data_width-1:0] cfg_rdata,
	output logic                               csb,
	output logic                               sclk,
	output logic                               sdio_out,
	output logic                               sdio_oe
);

	import adc_pkg::*;

	logic [lane_word_bits-1:0] lane_words;
	logic [ser_ratio-1:0]      frame_word;
	logic                      word_valid;
	logic                      slip;

	// ----------------------------------------------------------------------
	// receive path.
	// ----------------------------------------------------------------------
	// lane 0 is d0d, lane 7 is d1a.
	lane_bank i_lane_bank (
		.dco_clk    (dco_clk),
		.reset      (reset),
		.lane_in    ({d1a, d0a, d1b, d0b, d1c, d0c, d1d, d0d}),
		.frame_in   (fco),
		.slip       (slip),
		.lane_words (lane_words),
		.frame_word (frame_word),
		.word_valid (word_valid)
	);

	frame_align i_frame_align (
		.dco_clk      (dco_clk),
		.reset        (reset),
		.frame_word   (frame_word),
		.word_valid   (word_valid),
		.slip         (slip),
		.frame_locked (frame_locked)
	);

	sample_assembler i_sample_assembler (
		.dco_clk      (dco_clk),
		.reset        (reset),
		.lane_words   (lane_words),
		.word_valid   (word_valid),
		.frame_locked (frame_locked),
		.sample_a     (sample_a),
		.sample_b     (sample_b),
		.sample_c     (sample_c),
		.sample_d     (sample_d),
		.sample_valid (sample_valid)
	);

	// ----------------------------------------------------------------------
	// configuration port.
	// ----------------------------------------------------------------------
	spi_master i_spi_master (
		.dco_clk   (dco_clk),
		.reset     (reset),
		.cfg_req   (cfg_req),
		.cfg_rw    (cfg_rw),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.sdio_in   (sdio_in),
		.cfg_ack   (cfg_ack),
		.cfg_rdata (cfg_rdata),
		.csb       (csb),
		.sclk      (sclk),
		.sdio_out  (sdio_out),
		.sdio_oe   (sdio_oe)
	);

endmodule

// ==== dv/adc_rx_chk.sv ====
`timescale 1ns/100ps

module adc_rx_chk (
	input logic dco_clk,
	input logic reset,
	input logic cfg_req,
	input logic cfg_ack,
	input logic csb,
	input logic sclk,
	input logic word_valid,
	input logic sample_valid,
	input logic frame_locked
);

	import adc_pkg::*;

	// ack only answers a pending request.
	ack_needs_req: assert property (@(posedge dco_clk) disable iff (reset)
		$rose(cfg_ack) |-> cfg_req)
		else $error("cfg_ack rose while cfg_req was low");

	sclk_in_frame: assert property (@(posedge dco_clk) disable iff (reset)
		!$stable(sclk) |-> !csb)
		else $error("sclk toggled while csb was high");

	// a locked stream gives one sample per word until lock drops.
	valid_every_word: assert property (@(posedge dco_clk) disable iff (reset)
		sample_valid |-> ##ser_ratio (sample_valid || !frame_locked))
		else $error("sample stream broke while frame_locked");

	// a slip while locked would stretch the word by one bit.
	no_slip_locked: assert property (@(posedge dco_clk) disable iff (reset)
		frame_locked && word_valid |-> ##ser_ratio word_valid)
		else $error("word boundary moved while frame_locked");

endmodule

// ==== dv/adc_rx_tb.sv ====
`timescale 1ns/100ps

module adc_rx_tb;

	import adc_pkg::*;

	localparam int runs        = 3;
	localparam int lock_limit  = 48;
	localparam int rand_frames = 16;
	localparam int drain_limit = 8;
	localparam int spi_writes  = 8;
	localparam int frame_total = runs * (1 + lock_limit + rand_frames + drain_limit)
		+ 1 + 2 * lock_limit + rand_frames + drain_limit;
	localparam int spi_cycles  = 2 * spi_writes * (2 * spi_div * spi_frame_bits + 20);
	localparam int watchdog_cycles = 2 * (frame_total * ser_ratio + runs * 8 + spi_cycles);

	logic dco_clk, reset;
	logic d0a, d1a, d0b, d1b, d0c, d1c, d0d, d1d, fco;
	logic cfg_req, cfg_rw, sdio_in;
	logic [spi_addr_width-1:0] cfg_addr;
	logic [spi_data_width-1:0] cfg_wdata, cfg_rdata;
	logic [sample_width-1:0]   sample_a, sample_b, sample_c, sample_d;
	logic sample_valid, frame_locked, cfg_ack, csb, sclk, sdio_out, sdio_oe;

	logic [31:0]               lfsr;
	logic [4*sample_width-1:0] exp_q [$];
	logic [spi_data_width-1:0] model_regs [logic [spi_addr_width-1:0]];
	logic [spi_data_width-1:0] slave_regs [logic [spi_addr_width-1:0]];
	logic [spi_addr_width-1:0] wr_addr [$];
	logic                      exp_rw;
	logic [spi_addr_width-1:0] exp_addr;
	logic [spi_data_width-1:0] exp_wdata;
	int check_cnt;
	int error_cnt;

	adc_rx_top i_adc_rx_top (.*);

	bind adc_rx_top adc_rx_chk i_adc_rx_chk (
		.dco_clk(dco_clk), .reset(reset), .cfg_req(cfg_req), .cfg_ack(cfg_ack),
		.csb(csb), .sclk(sclk), .word_valid(word_valid),
		.sample_valid(sample_valid), .frame_locked(frame_locked)
	);

	initial begin
		dco_clk = 1'b0;
		forever #20 dco_clk = ~dco_clk;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge dco_clk);
		$display("ERROR: watchdog expired after %0d cycles", watchdog_cycles);
		$display("Some tests failed");
		$finish;
	end

	// ----------------------------------------------------------------------
	// random bits and compare tasks.
	// ----------------------------------------------------------------------
	// taps 32, 22, 2, 1.
	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = next_lfsr(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [spi_data_width-1:0] fill_value(input logic [spi_addr_width-1:0] a);
		return a[7:0] ^ {3'b000, a[12:8]} ^ 8'ha5;
	endfunction

	task automatic report_error(input string msg);
		error_cnt++;
		$display("ERROR: %s at %0t", msg, $time);
	endtask

	task automatic check_sample(input string name, input logic [sample_width-1:0] got,
		input logic [sample_width-1:0] exp);
		check_cnt++;
		if (got !== exp) begin
			error_cnt++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_rdata(input string name, input logic [spi_data_width-1:0] got,
		input logic [spi_data_width-1:0] exp);
		check_cnt++;
		if (got !== exp) begin
			error_cnt++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input logic [spi_addr_width-1:0] got,
		input logic [spi_addr_width-1:0] exp);
		check_cnt++;
		if (got !== exp) begin
			error_cnt++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		check_cnt++;
		if (got !== exp) begin
			error_cnt++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// ----------------------------------------------------------------------
	// lane serializer.
	// ----------------------------------------------------------------------
	// d1 carries the odd sample bits, msb first.
	task automatic send_frame(input logic [4*sample_width-1:0] s, input int first_bit);
		logic [4*sample_width-1:0] sh;
		logic [ser_ratio-1:0]      fr;
		for (int k = first_bit; k < ser_ratio; k++) begin
			@(negedge dco_clk);
			sh  = s << (2 * k);
			fr  = frame_pattern << k;
			d1a = sh[63];
			d0a = sh[62];
			d1b = sh[47];
			d0b = sh[46];
			d1c = sh[31];
			d0c = sh[30];
			d1d = sh[15];
			d0d = sh[14];
			fco = fr[7];
		end
	endtask

	task automatic send_random();
		logic [31:0] hi;
		logic [31:0] lo;
		do begin
			take_bits(32, hi);
			take_bits(32, lo);
		end while ({hi, lo} == '0);
		exp_q.push_back({hi, lo});
		send_frame({hi, lo}, 0);
	endtask

	task automatic acquire_lock(input logic target);
		int n;
		n = 0;
		while (frame_locked !== target && n < lock_limit) begin
			send_frame('0, 0);
			n++;
		end
		if (frame_locked !== target)
			report_error($sformatf("frame_locked did not reach %0b within %0d frames",
				target, lock_limit));
	endtask

	task automatic drain_samples();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < drain_limit) begin
			send_frame('0, 0);
			n++;
		end
		if (exp_q.size() != 0) begin
			report_error($sformatf("%0d expected sample sets never appeared", exp_q.size()));
			exp_q.delete();
		end
	endtask

	task automatic do_reset();
		@(negedge dco_clk);
		reset = 1'b1;
		{d0a, d1a, d0b, d1b, d0c, d1c, d0d, d1d, fco} = '0;
		cfg_req = 1'b0;
		repeat (4) @(negedge dco_clk);
		check_flag("csb", csb, 1'b1);
		check_flag("sdio_oe", sdio_oe, 1'b1);
		check_flag("sclk", sclk, 1'b0);
		check_flag("cfg_ack", cfg_ack, 1'b0);
		check_flag("sample_valid", sample_valid, 1'b0);
		check_flag("frame_locked", frame_locked, 1'b0);
		reset = 1'b0;
	endtask

	// ----------------------------------------------------------------------
	// spi requester and slave model.
	// ----------------------------------------------------------------------
	task automatic spi_transfer(input logic rw, input logic [spi_addr_width-1:0] addr,
		input logic [spi_data_width-1:0] wdata, output logic [spi_data_width-1:0] rdata);
		logic [31:0] hold;
		take_bits(3, hold);
		@(negedge dco_clk);
		exp_rw    = rw;
		exp_addr  = addr;
		exp_wdata = wdata;
		cfg_rw    = rw;
		cfg_addr  = addr;
		cfg_wdata = wdata;
		cfg_req   = 1'b1;
		do @(negedge dco_clk); while (!cfg_ack);
		rdata = cfg_rdata;
		// ack must hold and no new frame may start while req stays high.
		repeat (hold[2:0]) begin
			@(negedge dco_clk);
			check_flag("cfg_ack", cfg_ack, 1'b1);
			check_flag("csb", csb, 1'b1);
		end
		cfg_req = 1'b0;
		do begin
			@(negedge dco_clk);
			check_flag("csb", csb, 1'b1);
		end while (cfg_ack);
	endtask

	initial begin : spi_slave
		logic [spi_frame_bits-1:0] frame;
		logic [spi_addr_width-1:0] addr;
		logic [spi_data_width-1:0] rd_word;
		logic                      is_rd;
		sdio_in = 1'b0;
		forever begin
			@(negedge csb);
			frame = '0;
			is_rd = 1'b0;
			for (int i = 0; i < spi_frame_bits; i++) begin
				if (is_rd && i >= spi_instr_bits) begin
					@(negedge sclk);
					@(negedge dco_clk);
					check_flag("sdio_oe", sdio_oe, 1'b0);
					sdio_in = rd_word[7];
					rd_word = rd_word << 1;
				end
				@(posedge sclk);
				frame = {frame[spi_frame_bits-2:0], sdio_out};
				if (i == spi_instr_bits - 1) begin
					is_rd   = frame[15];
					addr    = frame[12:0];
					rd_word = slave_regs.exists(addr) ? slave_regs[addr] : fill_value(addr);
					check_flag("spi rw", frame[15], exp_rw);
					check_flag("spi w1", frame[14], 1'b0);
					check_flag("spi w0", frame[13], 1'b0);
					check_addr("spi addr", addr, exp_addr);
				end
			end
			if (!is_rd) begin
				check_rdata("spi wdata", frame[7:0], exp_wdata);
				slave_regs[addr] = frame[7:0];
			end
		end
	end

	// training frames are all zero, so only nonzero sets are matched.
	initial begin : sample_monitor
		logic [4*sample_width-1:0] got;
		logic [4*sample_width-1:0] exp;
		forever begin
			@(negedge dco_clk);
			got = {sample_a, sample_b, sample_c, sample_d};
			if (sample_valid && got != '0) begin
				if (exp_q.size() == 0) begin
					report_error("sample_valid with nonzero samples that were never sent");
				end else begin
					exp = exp_q.pop_front();
					check_sample("sample_a", sample_a, exp[63:48]);
					check_sample("sample_b", sample_b, exp[47:32]);
					check_sample("sample_c", sample_c, exp[31:16]);
					check_sample("sample_d", sample_d, exp[15:0]);
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// test sequence.
	// ----------------------------------------------------------------------
	initial begin
		logic [31:0]               off;
		logic [31:0]               rnd;
		logic [spi_data_width-1:0] rd;
		reset = 1'b1;
		{d0a, d1a, d0b, d1b, d0c, d1c, d0d, d1d, fco} = '0;
		cfg_req   = 1'b0;
		cfg_rw    = 1'b0;
		cfg_addr  = '0;
		cfg_wdata = '0;
		lfsr      = 32'hd98f_78ca;
		check_cnt = 0;
		error_cnt = 0;

		for (int run = 0; run < runs; run++) begin
			do_reset();
			take_bits(3, off);
			repeat (off[2:0]) @(negedge dco_clk);
			acquire_lock(1'b1);
			repeat (rand_frames) send_random();
			drain_samples();
			if (run == runs - 1) begin
				// one bit lost on every lane.
				send_frame('0, 1);
				acquire_lock(1'b0);
				acquire_lock(1'b1);
				repeat (rand_frames) send_random();
				drain_samples();
			end
		end

		for (int i = 0; i < spi_writes; i++) begin
			take_bits(spi_addr_width, off);
			take_bits(spi_data_width, rnd);
			model_regs[off[12:0]] = rnd[7:0];
			wr_addr.push_back(off[12:0]);
			spi_transfer(1'b0, off[12:0], rnd[7:0], rd);
		end
		for (int i = 0; i < spi_writes; i++) begin
			spi_transfer(1'b1, wr_addr[i], 8'h00, rd);
			check_rdata("cfg_rdata", rd, model_regs[wr_addr[i]]);
		end

		$display("Summary: %0d checks, %0d errors", check_cnt, error_cnt);
		if (error_cnt == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== flist.f ====
verilog/adc_pkg.sv
verilog/lane_bank.sv
verilog/frame_align.sv
verilog/sample_assembler.sv
verilog/spi_master.sv
verilog/adc_rx_top.sv
dv/adc_rx_chk.sv
dv/adc_rx_tb.sv

// ==== Makefile ====
# Verilator simulation of the ADC receive interface.

VERILATOR ?= verilator
TOP       ?= adc_rx_tb
BUILD_DIR ?= build
LOG       ?= sim.log
FLIST     ?= flist.f
VFLAGS    ?= --binary --timing --assert

FAIL_MSG := Some tests failed
PASS_MSG := All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
